// File: hdl/fft_pkg.sv
// Shared definitions for the FFT control core: widths, register map,
// run configuration and the job record passed to the external datapath
package fft_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////
    localparam int ADR_W     = 32;
    localparam int DATA_W    = 32;
    localparam int BSEL_W    = 4;
    localparam int NUM_W     = 12;
    localparam int REG_ADR_W = 4;

    typedef logic [ADR_W-1:0]     adr_t;
    typedef logic [DATA_W-1:0]    bus_data_t;
    typedef logic [BSEL_W-1:0]    bsel_t;
    typedef logic [NUM_W-1:0]     num_t;
    typedef logic [REG_ADR_W-1:0] reg_adr_t;

    localparam int MAX_STAGES   = 4;
    localparam int SAMPLE_BYTES = 4;

    // Recursion depth index
    typedef logic [$clog2(MAX_STAGES)-1:0] stage_idx_t;

    ////////////////////////////////////////
    // Register map
    ////////////////////////////////////////
    localparam reg_adr_t CONTROL_ADR = 4'd0;
    localparam reg_adr_t STATUS_ADR  = 4'd1;
    localparam reg_adr_t SIZE_ADR    = 4'd2;
    localparam reg_adr_t SOURCE_ADR  = 4'd3;
    localparam reg_adr_t DEST_ADR    = 4'd4;
    localparam reg_adr_t FACTORS_ADR = 4'd8;

    localparam int START_BIT   = 0;
    localparam int INTEN_BIT   = 8;
    localparam int INV_BIT     = 16;
    localparam int RUNNING_BIT = 0;
    localparam int FINISH_BIT  = 2;

    // Factor word has m in the low half, p from this bit up
    localparam int FACTOR_P_LSB = 16;

    typedef struct packed {
        num_t p;
        num_t m;
    } factor_t;

    typedef struct packed {
        adr_t                        src;
        adr_t                        dst;
        logic                        inv;
        factor_t [MAX_STAGES-1:0]    factors;
    } run_cfg_t;

    typedef enum logic [0:0] {
        JOB_COPY,
        JOB_BUTTERFLY
    } job_kind_e;

    // src is zero for butterfly jobs
    typedef struct packed {
        job_kind_e kind;
        adr_t      src;
        adr_t      dst;
        num_t      fstride;
        num_t      m;
        num_t      p;
        logic      inv;
    } job_t;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_INIT,
        ST_LOOP_INIT,
        ST_LOOP,
        ST_SAVE,
        ST_CALL,
        ST_RETURN,
        ST_RESTORE,
        ST_ISSUE_COPY,
        ST_WAIT_COPY,
        ST_ISSUE_BFLY,
        ST_WAIT_BFLY,
        ST_FINISH
    } seq_state_e;

endpackage

// File: hdl/fft_ctrl_regs.sv
// Register file of the FFT control core
// Holds the run configuration, builds the registered read-back, turns a
// start write into a pulse and keeps the finish flag and interrupt
`timescale 1ns/1ps

module fft_ctrl_regs (
    input  logic                clk_i,
    input  logic                rst_i,
    input  fft_pkg::reg_adr_t   reg_adr_i,
    input  fft_pkg::bus_data_t  reg_dat_i,
    input  fft_pkg::bsel_t      reg_bsel_i,
    input  logic                reg_wr_i,
    input  logic                reg_rd_i,
    output fft_pkg::bus_data_t  reg_dat_o,
    output logic                reg_ack_o,
    input  logic                busy_i,
    input  logic                run_done_i,
    output logic                start_o,
    output fft_pkg::run_cfg_t   cfg_o,
    output logic                irq_o,
    output logic                event_o
);
    import fft_pkg::*;

    num_t      size_q;
    adr_t      src_q;
    adr_t      dst_q;
    logic      inv_q;
    logic      inten_q;
    logic      start_q;
    logic      finish_q;
    logic      rd_ack_q;
    bus_data_t rd_data;
    bus_data_t rd_data_q;
    logic      ctrl_wr;
    logic      cfg_wr;
    factor_t   factors_q [MAX_STAGES];

    function automatic bus_data_t merge_bytes(bus_data_t old_w, bus_data_t new_w, bsel_t bsel);
        bus_data_t res;
        res = old_w;
        for (int b = 0; b < BSEL_W; b++) begin
            if (bsel[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic bus_data_t factor_word(factor_t f);
        bus_data_t w;
        w = '0;
        w[0 +: NUM_W] = f.m;
        w[FACTOR_P_LSB +: NUM_W] = f.p;
        return w;
    endfunction

    function automatic factor_t factor_from_word(bus_data_t w);
        factor_t f;
        f.m = w[0 +: NUM_W];
        f.p = w[FACTOR_P_LSB +: NUM_W];
        return f;
    endfunction

    ////////////////////////////////////////
    // Register writes
    ////////////////////////////////////////
    assign ctrl_wr = reg_wr_i && (reg_adr_i == CONTROL_ADR);
    // Run configuration is frozen from the start pulse to the end of the run
    assign cfg_wr  = reg_wr_i && !busy_i && !start_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            size_q  <= '0;
            src_q   <= '0;
            dst_q   <= '0;
            inv_q   <= 1'b0;
            inten_q <= 1'b0;
            for (int s = 0; s < MAX_STAGES; s++) begin
                factors_q[s] <= '0;
            end
        end else begin
            if (ctrl_wr && reg_bsel_i[INTEN_BIT/8]) begin
                inten_q <= reg_dat_i[INTEN_BIT];
            end
            if (cfg_wr) begin
                if (reg_adr_i == CONTROL_ADR && reg_bsel_i[INV_BIT/8]) begin
                    inv_q <= reg_dat_i[INV_BIT];
                end
                if (reg_adr_i == SIZE_ADR) begin
                    size_q <= num_t'(merge_bytes(bus_data_t'(size_q), reg_dat_i, reg_bsel_i));
                end
                if (reg_adr_i == SOURCE_ADR) begin
                    src_q <= merge_bytes(src_q, reg_dat_i, reg_bsel_i);
                end
                if (reg_adr_i == DEST_ADR) begin
                    dst_q <= merge_bytes(dst_q, reg_dat_i, reg_bsel_i);
                end
                for (int s = 0; s < MAX_STAGES; s++) begin
                    if (reg_adr_i == FACTORS_ADR + reg_adr_t'(s)) begin
                        factors_q[s] <= factor_from_word(
                            merge_bytes(factor_word(factors_q[s]), reg_dat_i, reg_bsel_i));
                    end
                end
            end
        end
    end

    // Start pulse only from an idle core
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            start_q  <= 1'b0;
            finish_q <= 1'b0;
        end else begin
            start_q <= ctrl_wr && reg_bsel_i[START_BIT/8] && reg_dat_i[START_BIT]
                       && !busy_i && !start_q;
            if (run_done_i) begin
                finish_q <= 1'b1;
            end else if (reg_rd_i && reg_adr_i == STATUS_ADR) begin
                finish_q <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Read-back
    ////////////////////////////////////////
    always_comb begin
        rd_data = '0;
        case (reg_adr_i)
            CONTROL_ADR: begin
                rd_data[INTEN_BIT] = inten_q;
                rd_data[INV_BIT]   = inv_q;
            end
            STATUS_ADR: begin
                rd_data[RUNNING_BIT] = busy_i;
                rd_data[FINISH_BIT]  = finish_q;
            end
            SIZE_ADR:   rd_data[0 +: NUM_W] = size_q;
            SOURCE_ADR: rd_data = src_q;
            DEST_ADR:   rd_data = dst_q;
            default: begin
                for (int s = 0; s < MAX_STAGES; s++) begin
                    if (reg_adr_i == FACTORS_ADR + reg_adr_t'(s)) begin
                        rd_data = factor_word(factors_q[s]);
                    end
                end
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_ack_q  <= 1'b0;
            rd_data_q <= '0;
        end else begin
            rd_ack_q <= reg_rd_i;
            if (reg_rd_i) begin
                rd_data_q <= rd_data;
            end
        end
    end

    assign reg_dat_o = rd_data_q;
    // Writes ack in the same cycle, reads one cycle later
    assign reg_ack_o = rd_ack_q | reg_wr_i;

    assign start_o = start_q;
    always_comb begin
        cfg_o.src = src_q;
        cfg_o.dst = dst_q;
        cfg_o.inv = inv_q;
        for (int s = 0; s < MAX_STAGES; s++) begin
            cfg_o.factors[s] = factors_q[s];
        end
    end

    assign irq_o   = inten_q & finish_q;
    assign event_o = finish_q;

endmodule

// File: hdl/fft_stage_sequencer.sv
// Stage sequencer of the FFT control core
// Walks the decimation-in-time recursion with a per-stage context stack
// and issues copy and butterfly jobs, one at a time
`timescale 1ns/1ps

module fft_stage_sequencer (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              start_i,
    input  fft_pkg::run_cfg_t cfg_i,
    input  logic              job_done_i,
    output fft_pkg::job_t     job_o,
    output logic              job_valid_o,
    output logic              busy_o,
    output logic              run_done_o
);
    import fft_pkg::*;

    // One recursion frame
    typedef struct packed {
        adr_t in_adr;
        adr_t out_adr;
        adr_t base_adr;
        num_t fstride;
        num_t count;
    } frame_t;

    seq_state_e state_q;
    seq_state_e state_d;
    stage_idx_t lvl_q;
    frame_t     ctx_q;
    frame_t     stack_q [MAX_STAGES];
    frame_t     top;
    factor_t    cur_f;
    logic       is_copy;

    assign cur_f   = cfg_i.factors[lvl_q];
    assign top     = stack_q[lvl_q];
    assign is_copy = (state_q == ST_ISSUE_COPY);

    ////////////////////////////////////////
    // State machine
    ////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (start_i) begin
                    state_d = ST_INIT;
                end
            end
            ST_INIT:      state_d = ST_LOOP_INIT;
            ST_LOOP_INIT: state_d = ST_LOOP;
            ST_LOOP: begin
                if (cur_f.m == num_t'(1)) begin
                    state_d = ST_ISSUE_COPY;
                end else if (ctx_q.count == '0) begin
                    state_d = ST_ISSUE_BFLY;
                end else begin
                    state_d = ST_SAVE;
                end
            end
            ST_SAVE:       state_d = ST_CALL;
            ST_CALL:       state_d = ST_LOOP_INIT;
            ST_ISSUE_COPY: state_d = ST_WAIT_COPY;
            ST_WAIT_COPY: begin
                if (job_done_i) begin
                    state_d = ST_ISSUE_BFLY;
                end
            end
            ST_ISSUE_BFLY: state_d = ST_WAIT_BFLY;
            ST_WAIT_BFLY: begin
                if (job_done_i) begin
                    state_d = (lvl_q == '0) ? ST_FINISH : ST_RETURN;
                end
            end
            ST_RETURN:  state_d = ST_RESTORE;
            ST_RESTORE: state_d = ST_LOOP;
            ST_FINISH:  state_d = ST_IDLE;
            default:    state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            lvl_q <= '0;
        end else begin
            case (state_q)
                ST_INIT:   lvl_q <= '0;
                ST_CALL:   lvl_q <= lvl_q + 1'b1;
                ST_RETURN: lvl_q <= lvl_q - 1'b1;
                default:   ;
            endcase
        end
    end

    ////////////////////////////////////////
    // Context and stack
    ////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        case (state_q)
            ST_INIT: begin
                ctx_q.in_adr   <= cfg_i.src;
                ctx_q.out_adr  <= cfg_i.dst;
                ctx_q.base_adr <= cfg_i.dst;
                ctx_q.fstride  <= num_t'(1);
            end
            ST_LOOP_INIT: ctx_q.count <= cur_f.p;
            ST_SAVE: begin
                // Child starts at the parent's current addresses
                stack_q[lvl_q]  <= ctx_q;
                ctx_q.base_adr  <= ctx_q.out_adr;
                ctx_q.fstride   <= ctx_q.fstride * cur_f.p;
            end
            ST_RESTORE: begin
                // Step to the next sub-transform of the parent
                ctx_q.in_adr   <= top.in_adr + adr_t'(top.fstride) * adr_t'(SAMPLE_BYTES);
                ctx_q.out_adr  <= top.out_adr + adr_t'(cur_f.m) * adr_t'(SAMPLE_BYTES);
                ctx_q.base_adr <= top.base_adr;
                ctx_q.fstride  <= top.fstride;
                ctx_q.count    <= top.count - num_t'(1);
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////
    // Job issue
    ////////////////////////////////////////
    always_comb begin
        job_o         = '0;
        job_o.kind    = is_copy ? JOB_COPY : JOB_BUTTERFLY;
        job_o.src     = is_copy ? ctx_q.in_adr : '0;
        job_o.dst     = is_copy ? ctx_q.out_adr : ctx_q.base_adr;
        job_o.fstride = ctx_q.fstride;
        job_o.m       = cur_f.m;
        job_o.p       = cur_f.p;
        job_o.inv     = cfg_i.inv;
    end

    assign job_valid_o = is_copy || (state_q == ST_ISSUE_BFLY);
    assign busy_o      = (state_q != ST_IDLE);
    assign run_done_o  = (state_q == ST_FINISH);

endmodule

// File: hdl/fft_job_port.sv
// Job output port of the FFT control core
// Holds one job and runs the four-phase req/ack exchange with the
// external datapath, then reports completion to the sequencer
`timescale 1ns/1ps

module fft_job_port (
    input  logic          clk_i,
    input  logic          rst_i,
    input  fft_pkg::job_t job_i,
    input  logic          job_valid_i,
    input  logic          job_ack_i,
    output logic          job_done_o,
    output logic          job_req_o,
    output fft_pkg::job_t job_o
);
    import fft_pkg::*;

    typedef enum logic [1:0] {
        PORT_IDLE,
        PORT_REQ,
        PORT_RELEASE
    } port_state_e;

    port_state_e state_q;
    job_t        job_q;
    logic        done_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= PORT_IDLE;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                PORT_IDLE: begin
                    if (job_valid_i) begin
                        state_q <= PORT_REQ;
                    end
                end
                // Hold request until the datapath is finished
                PORT_REQ: begin
                    if (job_ack_i) begin
                        state_q <= PORT_RELEASE;
                    end
                end
                PORT_RELEASE: begin
                    if (!job_ack_i) begin
                        state_q <= PORT_IDLE;
                        done_q  <= 1'b1;
                    end
                end
                default: state_q <= PORT_IDLE;
            endcase
        end
    end

    // Job captured once and held through the exchange
    always_ff @(posedge clk_i) begin
        if (state_q == PORT_IDLE && job_valid_i) begin
            job_q <= job_i;
        end
    end

    assign job_req_o  = (state_q == PORT_REQ);
    assign job_o      = job_q;
    assign job_done_o = done_q;

endmodule

// File: hdl/fft_core_top.sv
// Top level of the FFT control core
// Register file, stage sequencer and job port joined by wires
`timescale 1ns/1ps

module fft_core_top (
    input  logic               clk_i,
    input  logic               rst_i,
    input  fft_pkg::reg_adr_t  reg_adr_i,
    input  fft_pkg::bus_data_t reg_dat_i,
    input  fft_pkg::bsel_t     reg_bsel_i,
    input  logic               reg_wr_i,
    input  logic               reg_rd_i,
    output fft_pkg::bus_data_t reg_dat_o,
    output logic               reg_ack_o,
    output logic               job_req_o,
    output fft_pkg::job_t      job_o,
    input  logic               job_ack_i,
    output logic               irq_o,
    output logic               event_o
);
    import fft_pkg::*;

    logic     start;
    logic     busy;
    logic     run_done;
    run_cfg_t cfg;
    job_t     job;
    logic     job_valid;
    logic     job_done;

    fft_ctrl_regs u_regs (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .reg_adr_i  (reg_adr_i),
        .reg_dat_i  (reg_dat_i),
        .reg_bsel_i (reg_bsel_i),
        .reg_wr_i   (reg_wr_i),
        .reg_rd_i   (reg_rd_i),
        .reg_dat_o  (reg_dat_o),
        .reg_ack_o  (reg_ack_o),
        .busy_i     (busy),
        .run_done_i (run_done),
        .start_o    (start),
        .cfg_o      (cfg),
        .irq_o      (irq_o),
        .event_o    (event_o)
    );

    fft_stage_sequencer u_seq (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .start_i     (start),
        .cfg_i       (cfg),
        .job_done_i  (job_done),
        .job_o       (job),
        .job_valid_o (job_valid),
        .busy_o      (busy),
        .run_done_o  (run_done)
    );

    fft_job_port u_port (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .job_i       (job),
        .job_valid_i (job_valid),
        .job_ack_i   (job_ack_i),
        .job_done_o  (job_done),
        .job_req_o   (job_req_o),
        .job_o       (job_o)
    );

endmodule

// File: sim/fft_core_properties.sv
// Assertions on the four-phase job port and the register bus read timing
// Bound into the core top level
`timescale 1ns/1ps

module fft_core_properties (
    input logic          clk_i,
    input logic          rst_i,
    input logic          job_req_i,
    input logic          job_ack_i,
    input fft_pkg::job_t job_i,
    input logic          reg_rd_i,
    input logic          reg_ack_i
);

    req_held_until_ack: assert property (@(posedge clk_i) disable iff (rst_i)
        job_req_i && !job_ack_i |=> job_req_i)
        else $error("job_req_o dropped before job_ack_i");

    job_stable_in_req: assert property (@(posedge clk_i) disable iff (rst_i)
        $past(job_req_i) && job_req_i |-> $stable(job_i))
        else $error("job_o changed while job_req_o was high");

    // New request only once the previous ack is gone
    no_req_during_ack: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(job_req_i) |-> !job_ack_i)
        else $error("job_req_o rose while job_ack_i was high");

    read_ack_timing: assert property (@(posedge clk_i) disable iff (rst_i)
        reg_rd_i |=> reg_ack_i)
        else $error("reg_ack_o missing one cycle after reg_rd_i");

endmodule

bind fft_core_top fft_core_properties u_props (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .job_req_i (job_req_o),
    .job_ack_i (job_ack_i),
    .job_i     (job_o),
    .reg_rd_i  (reg_rd_i),
    .reg_ack_i (reg_ack_o)
);

// File: sim/fft_core_tb.sv
// Testbench for the FFT control core
// Programs the register file, runs job streams against a recursive reference
// model and answers each job on the four-phase port after a random delay
`timescale 1ns/1ps

module fft_core_tb;
    import fft_pkg::*;

    localparam int          SEED          = 36068;
    // About 150 jobs of up to 14 cycles each, three runs, plus margin
    localparam int          TIMEOUT_CYCLES = 40000;
    localparam int unsigned MAX_ACK_DELAY = 7;
    localparam int          HALF_PERIOD   = 20;
    localparam int          DRIVE_DELAY   = 2;
    // Cycles from the last ack release to the finish flag
    localparam int          FINISH_WAIT   = 8;

    typedef logic [127:0] wide_t;

    logic      clk_i;
    logic      rst_i;
    reg_adr_t  reg_adr_i;
    bus_data_t reg_dat_i;
    bsel_t     reg_bsel_i;
    logic      reg_wr_i;
    logic      reg_rd_i;
    bus_data_t reg_dat_o;
    logic      reg_ack_o;
    logic      job_req_o;
    job_t      job_o;
    logic      job_ack_i;
    logic      irq_o;
    logic      event_o;

    string     test_name;
    int        err_count;
    int        cycle_count;
    job_t      exp_q [$];
    num_t      cfg_p [MAX_STAGES];
    num_t      cfg_m [MAX_STAGES];
    logic      cfg_inv;

    fft_core_top u_fft_core_top (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .reg_adr_i  (reg_adr_i),
        .reg_dat_i  (reg_dat_i),
        .reg_bsel_i (reg_bsel_i),
        .reg_wr_i   (reg_wr_i),
        .reg_rd_i   (reg_rd_i),
        .reg_dat_o  (reg_dat_o),
        .reg_ack_o  (reg_ack_o),
        .job_req_o  (job_req_o),
        .job_o      (job_o),
        .job_ack_i  (job_ack_i),
        .irq_o      (irq_o),
        .event_o    (event_o)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #(HALF_PERIOD) clk_i = ~clk_i;
        end
    end

    ////////////////////////////////////////
    // Reporting
    ////////////////////////////////////////
    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_equal(input string what, input wide_t exp_v, input wide_t act_v);
        if (exp_v !== act_v) begin
            err_count++;
            $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp_v, act_v);
            abort_run("Stopping at the first mismatch");
        end
    endtask

    ////////////////////////////////////////
    // Register bus
    ////////////////////////////////////////
    task automatic bus_write(input reg_adr_t adr, input bus_data_t data, input bsel_t bsel);
        @(posedge clk_i);
        #(DRIVE_DELAY);
        reg_adr_i  = adr;
        reg_dat_i  = data;
        reg_bsel_i = bsel;
        reg_wr_i   = 1'b1;
        #1;
        check_equal("write ack", wide_t'(1'b1), wide_t'(reg_ack_o));
        @(posedge clk_i);
        #(DRIVE_DELAY);
        reg_wr_i = 1'b0;
    endtask

    task automatic bus_read(input reg_adr_t adr, output bus_data_t data);
        @(posedge clk_i);
        #(DRIVE_DELAY);
        reg_adr_i = adr;
        reg_rd_i  = 1'b1;
        @(posedge clk_i);
        #(DRIVE_DELAY);
        reg_rd_i = 1'b0;
        check_equal("read ack", wide_t'(1'b1), wide_t'(reg_ack_o));
        data = reg_dat_o;
    endtask

    function automatic bus_data_t byte_merge(bus_data_t old_w, bus_data_t new_w, bsel_t bsel);
        bus_data_t mask;
        mask = {{8{bsel[3]}}, {8{bsel[2]}}, {8{bsel[1]}}, {8{bsel[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    ////////////////////////////////////////
    // Reference job model
    ////////////////////////////////////////
    // Decimation-in-time walk, jobs appended in issue order
    function automatic void build_jobs(int s, adr_t in_adr, adr_t out_adr, num_t f);
        job_t j;
        j         = '0;
        j.dst     = out_adr;
        j.fstride = f;
        j.m       = cfg_m[s];
        j.p       = cfg_p[s];
        j.inv     = cfg_inv;
        if (cfg_m[s] == num_t'(1)) begin
            j.kind = JOB_COPY;
            j.src  = in_adr;
            exp_q.push_back(j);
        end else begin
            for (int k = 0; k < int'(cfg_p[s]); k++) begin
                build_jobs(s + 1,
                           in_adr + adr_t'(k) * adr_t'(f) * adr_t'(SAMPLE_BYTES),
                           out_adr + adr_t'(k) * adr_t'(cfg_m[s]) * adr_t'(SAMPLE_BYTES),
                           f * cfg_p[s]);
            end
        end
        j.kind = JOB_BUTTERFLY;
        j.src  = '0;
        exp_q.push_back(j);
    endfunction

    // External datapath stand-in, compares every job it receives
    initial begin : responder
        job_t        got;
        job_t        want;
        int unsigned delay;
        while (err_count == 0) begin
            @(negedge clk_i);
            if (job_req_o) begin
                got = job_o;
                if (exp_q.size() == 0) begin
                    err_count++;
                    abort_run($sformatf("Unexpected job in %s: %h", test_name, got));
                end else begin
                    want = exp_q.pop_front();
                    check_equal("job", wide_t'(want), wide_t'(got));
                    delay = $urandom % (MAX_ACK_DELAY + 1);
                    repeat (delay) @(posedge clk_i);
                    @(posedge clk_i);
                    #(DRIVE_DELAY);
                    job_ack_i = 1'b1;
                    @(negedge clk_i);
                    while (job_req_o) begin
                        @(negedge clk_i);
                    end
                    @(posedge clk_i);
                    #(DRIVE_DELAY);
                    job_ack_i = 1'b0;
                end
            end
        end
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycle_count++;
        end
        abort_run($sformatf("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES));
    end

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////
    task automatic wait_for_request();
        @(negedge clk_i);
        while (!job_req_o) begin
            @(negedge clk_i);
        end
    endtask

    task automatic register_test();
        reg_adr_t  adr;
        bus_data_t mask;
        bus_data_t shadow;
        bus_data_t data;
        bsel_t     bsel;
        bus_data_t rd;
        test_name = "register_access";
        for (int i = 0; i < 3 + MAX_STAGES; i++) begin
            case (i)
                0: begin
                    adr  = SIZE_ADR;
                    mask = 32'h0000_0FFF;
                end
                1: begin
                    adr  = SOURCE_ADR;
                    mask = 32'hFFFF_FFFF;
                end
                2: begin
                    adr  = DEST_ADR;
                    mask = 32'hFFFF_FFFF;
                end
                default: begin
                    adr  = FACTORS_ADR + reg_adr_t'(i - 3);
                    mask = 32'h0FFF_0FFF;
                end
            endcase
            shadow = '0;
            for (int n = 0; n < 3; n++) begin
                data = bus_data_t'($urandom);
                bsel = (n == 0) ? 4'hF : bsel_t'($urandom);
                bus_write(adr, data, bsel);
                shadow = byte_merge(shadow, data, bsel) & mask;
                bus_read(adr, rd);
                check_equal($sformatf("read back 0x%h", adr), wide_t'(shadow), wide_t'(rd));
            end
        end
        bus_write(CONTROL_ADR, 32'h0001_0100, 4'hF);
        bus_read(CONTROL_ADR, rd);
        check_equal("control read back", wide_t'(32'h0001_0100), wide_t'(rd));
        bus_write(CONTROL_ADR, 32'h0000_0000, 4'hF);
        bus_read(STATUS_ADR, rd);
        check_equal("idle status", wide_t'(0), wide_t'(rd));
        for (int a = 5; a < 16; a++) begin
            if (a < 8 || a >= 8 + MAX_STAGES) begin
                bus_read(reg_adr_t'(a), rd);
                check_equal($sformatf("unmapped 0x%h", a), wide_t'(0), wide_t'(rd));
            end
        end
    endtask

    task automatic run_fft(input string name, input logic inv, input logic inten,
                           input logic mid_start);
        adr_t      src;
        adr_t      dst;
        bus_data_t ctrl;
        bus_data_t start_ctrl;
        bus_data_t rd;
        test_name = name;
        src = adr_t'($urandom) & ~adr_t'(3);
        dst = adr_t'($urandom) & ~adr_t'(3);
        cfg_inv = inv;
        for (int s = 0; s < MAX_STAGES; s++) begin
            bus_write(FACTORS_ADR + reg_adr_t'(s), {4'h0, cfg_p[s], 4'h0, cfg_m[s]}, 4'hF);
        end
        bus_write(SOURCE_ADR, src, 4'hF);
        bus_write(DEST_ADR, dst, 4'hF);
        ctrl            = '0;
        ctrl[INV_BIT]   = inv;
        ctrl[INTEN_BIT] = inten;
        bus_write(CONTROL_ADR, ctrl, 4'hF);
        exp_q.delete();
        build_jobs(0, src, dst, num_t'(1));
        start_ctrl            = ctrl;
        start_ctrl[START_BIT] = 1'b1;
        bus_write(CONTROL_ADR, start_ctrl, 4'hF);

        wait_for_request();
        bus_read(STATUS_ADR, rd);
        check_equal("status while running", wide_t'(bus_data_t'(1) << RUNNING_BIT), wide_t'(rd));
        // A second start during the run must be ignored
        if (mid_start) begin
            bus_write(CONTROL_ADR, start_ctrl, 4'hF);
        end

        // Ends early on event_o, else once the last modeled job is released
        while (!event_o && (exp_q.size() != 0 || job_req_o || job_ack_i)) begin
            @(negedge clk_i);
        end
        for (int c = 0; c < FINISH_WAIT && !event_o; c++) begin
            @(negedge clk_i);
        end
        check_equal("jobs left in model", wide_t'(0), wide_t'(exp_q.size()));
        check_equal("event_o at finish", wide_t'(1'b1), wide_t'(event_o));
        check_equal("irq_o at finish", wide_t'(inten), wide_t'(irq_o));
        bus_read(STATUS_ADR, rd);
        check_equal("status after run", wide_t'(bus_data_t'(1) << FINISH_BIT), wide_t'(rd));
        check_equal("event_o after status read", wide_t'(1'b0), wide_t'(event_o));
        check_equal("irq_o after status read", wide_t'(1'b0), wide_t'(irq_o));
    endtask

    initial begin : main
        void'($urandom(SEED));
        err_count  = 0;
        test_name  = "reset";
        rst_i      = 1'b1;
        reg_adr_i  = '0;
        reg_dat_i  = '0;
        reg_bsel_i = '0;
        reg_wr_i   = 1'b0;
        reg_rd_i   = 1'b0;
        job_ack_i  = 1'b0;
        cfg_inv    = 1'b0;
        repeat (8) @(posedge clk_i);
        #(DRIVE_DELAY);
        rst_i = 1'b0;
        check_equal("job_req_o after reset", wide_t'(1'b0), wide_t'(job_req_o));
        check_equal("irq_o after reset", wide_t'(1'b0), wide_t'(irq_o));
        check_equal("event_o after reset", wide_t'(1'b0), wide_t'(event_o));
        check_equal("reg_ack_o after reset", wide_t'(1'b0), wide_t'(reg_ack_o));

        register_test();

        cfg_p = '{12'd4, 12'd0, 12'd0, 12'd0};
        cfg_m = '{12'd1, 12'd0, 12'd0, 12'd0};
        run_fft("single_stage_p4", 1'b0, 1'b1, 1'b0);

        cfg_p = '{12'd4, 12'd4, 12'd4, 12'd4};
        cfg_m = '{12'd64, 12'd16, 12'd4, 12'd1};
        run_fft("radix4_256", 1'b1, 1'b0, 1'b1);

        cfg_p = '{12'd2, 12'd4, 12'd2, 12'd0};
        cfg_m = '{12'd8, 12'd2, 12'd1, 12'd0};
        run_fft("mixed_2x4x2", 1'b0, 1'b1, 1'b0);

        // Idle tail catches any stray job
        repeat (20) @(posedge clk_i);
        if (err_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            abort_run("Checks failed during the run");
        end
    end

endmodule

// File: vlog.f
hdl/fft_pkg.sv
hdl/fft_ctrl_regs.sv
hdl/fft_stage_sequencer.sv
hdl/fft_job_port.sv
hdl/fft_core_top.sv
sim/fft_core_properties.sv
sim/fft_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run the testbench and look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f vlog.f --top-module fft_core_tb -Mdir obj_dir \
        > build.log 2>&1 &&
    ./obj_dir/Vfft_core_tb > sim.log 2>&1 &&
    grep -q '^>>> PASS$' sim.log &&
    echo "Simulation passed" ||
    { echo "Simulation failed, see build.log and sim.log"; exit 1; }
